// File: logic/gfx_pkg.sv
//==========================================================================
// gfx package: shared coordinate, color and length types, screen size,
// line engine states and the pixel to frame buffer address mapping
//==========================================================================
package gfx_pkg;

  localparam int FB_W  = 32;  // screen width in pixels
  localparam int FB_H  = 32;  // screen height in pixels
  localparam int FB_XW = $clog2(FB_W);
  localparam int FB_YW = $clog2(FB_H);
  localparam int FB_AW = $clog2(FB_W * FB_H);

  typedef logic [15:0]      coord_t;  // coordinate or Bresenham delta
  typedef logic [15:0]      color_t;
  typedef logic [15:0]      len_t;    // run length in pixels
  typedef logic [FB_AW-1:0] fb_addr_t;

  typedef enum logic [2:0] {
    st_idle,
    st_orient,
    st_order,
    st_setup,
    st_run,
    st_emit,
    st_wait_ack,
    st_done
  } draw_state_t;

  // row major, y in the upper bits
  function automatic fb_addr_t fb_addr(input coord_t x, input coord_t y);
    return {y[FB_YW-1:0], x[FB_XW-1:0]};
  endfunction

endpackage

// File: logic/seg_if.sv
//==========================================================================
// run segment channel from the line engine to the span writer,
// four-phase req/ack with fields held stable while req is high
//==========================================================================
interface seg_if
  import gfx_pkg::*;
();

  logic   req;
  logic   ack;
  coord_t x;         // first pixel of the run
  coord_t y;
  len_t   len;       // pixels in the run
  logic   vertical;  // step y instead of x
  color_t color;

  modport master (
    output req,
    output x,
    output y,
    output len,
    output vertical,
    output color,
    input  ack
  );

  modport slave (
    input  req,
    input  x,
    input  y,
    input  len,
    input  vertical,
    input  color,
    output ack
  );

endinterface

// File: logic/line_draw.sv
//==========================================================================
// Bresenham line engine, walks the major axis left to right and sends
// the line out as horizontal/vertical runs or single pixels
//==========================================================================
module line_draw
  import gfx_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   cmd_req,
  output logic   cmd_ack,
  input  coord_t x0,
  input  coord_t y0,
  input  coord_t x1,
  input  coord_t y1,
  input  color_t color,
  seg_if.master  seg
);

  draw_state_t state;

  // working endpoints, a is the major axis after orient
  coord_t ax0, ay0, ax1, ay1;
  coord_t dx, dy, err;
  logic   steep;
  logic   ystep;     // minor axis direction, 1 is increasing
  logic   run_mode;  // shallow line, emit whole runs
  logic   last_seg;

  // run being accumulated, in oriented coordinates
  coord_t run_x, run_y;
  len_t   run_len;

  logic   minor_step;
  logic   emit_now;
  coord_t y_next;

  assign minor_step = err < dy;  // err - dy would go negative
  assign y_next     = ystep ? ay0 + 16'd1 : ay0 - 16'd1;
  assign emit_now   = (ax0 == ax1) || minor_step || !run_mode;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= st_idle;
      cmd_ack      <= 1'b0;
      ax0          <= '0;
      ay0          <= '0;
      ax1          <= '0;
      ay1          <= '0;
      dx           <= '0;
      dy           <= '0;
      err          <= '0;
      steep        <= 1'b0;
      ystep        <= 1'b0;
      run_mode     <= 1'b0;
      last_seg     <= 1'b0;
      run_x        <= '0;
      run_y        <= '0;
      run_len      <= '0;
      seg.req      <= 1'b0;
      seg.x        <= '0;
      seg.y        <= '0;
      seg.len      <= '0;
      seg.vertical <= 1'b0;
      seg.color    <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (cmd_req && !cmd_ack) begin
            ax0       <= x0;
            ay0       <= y0;
            ax1       <= x1;
            ay1       <= y1;
            dx        <= (x1 > x0) ? x1 - x0 : x0 - x1;
            dy        <= (y1 > y0) ? y1 - y0 : y0 - y1;
            seg.color <= color;  // one color for the whole line
            state     <= st_orient;
          end
        end
        st_orient: begin
          steep <= dy > dx;
          if (dy > dx) begin  // steep, walk along y instead
            ax0 <= ay0;
            ay0 <= ax0;
            ax1 <= ay1;
            ay1 <= ax1;
            dx  <= dy;
            dy  <= dx;
          end
          state <= st_order;
        end
        st_order: begin
          if (ax0 > ax1) begin  // left to right
            ax0 <= ax1;
            ax1 <= ax0;
            ay0 <= ay1;
            ay1 <= ay0;
          end
          err      <= dx >> 1;
          run_mode <= {1'b0, dx} > {dy, 1'b0};
          state    <= st_setup;
        end
        st_setup: begin
          ystep    <= ay0 < ay1;
          run_x    <= ax0;
          run_y    <= ay0;
          run_len  <= 16'd1;
          last_seg <= 1'b0;
          state    <= st_run;
        end
        st_run: begin
          if (emit_now) begin
            seg.req      <= 1'b1;
            seg.x        <= steep ? run_y : run_x;  // swap back
            seg.y        <= steep ? run_x : run_y;
            seg.len      <= run_len;
            seg.vertical <= steep;
            state        <= st_emit;
          end
          if (ax0 == ax1) begin
            last_seg <= 1'b1;  // final endpoint reached
          end else begin
            ax0 <= ax0 + 16'd1;
            if (minor_step) begin
              ay0 <= y_next;
              err <= err - dy + dx;
            end else begin
              err <= err - dy;
            end
            if (emit_now) begin  // next run starts at the new pixel
              run_x   <= ax0 + 16'd1;
              run_y   <= minor_step ? y_next : ay0;
              run_len <= 16'd1;
            end else begin
              run_len <= run_len + 16'd1;
            end
          end
        end
        st_emit: begin
          if (seg.ack) begin
            seg.req <= 1'b0;
            state   <= st_wait_ack;
          end
        end
        st_wait_ack: begin
          if (!seg.ack) begin
            if (last_seg) begin
              cmd_ack <= 1'b1;  // every pixel is written by now
              state   <= st_done;
            end else begin
              state <= st_run;
            end
          end
        end
        st_done: begin
          if (!cmd_req) begin
            cmd_ack <= 1'b0;
            state   <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// File: logic/span_writer.sv
//==========================================================================
// span writer, expands one run into single-pixel frame buffer writes
// and drops pixels that fall outside the screen
//==========================================================================
module span_writer
  import gfx_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  seg_if.slave     seg,
  output logic     wr_en,
  output fb_addr_t wr_addr,
  output color_t   wr_data
);

  coord_t cur_x, cur_y;
  len_t   remain;     // pixels still to write, current one included
  logic   vert;
  logic   busy;
  color_t pix_color;
  logic   on_screen;

  // full compare, large coordinates must not wrap onto the screen
  assign on_screen = (cur_x < FB_W) && (cur_y < FB_H);

  assign wr_en   = busy && on_screen;
  assign wr_addr = fb_addr(cur_x, cur_y);
  assign wr_data = pix_color;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      seg.ack   <= 1'b0;
      cur_x     <= '0;
      cur_y     <= '0;
      remain    <= '0;
      vert      <= 1'b0;
      pix_color <= '0;
    end else if (busy) begin
      if (vert) begin
        cur_y <= cur_y + 16'd1;
      end else begin
        cur_x <= cur_x + 16'd1;
      end
      remain <= remain - 16'd1;
      if (remain == 16'd1) begin  // last pixel goes out this cycle
        busy    <= 1'b0;
        seg.ack <= 1'b1;
      end
    end else if (seg.ack) begin
      if (!seg.req) begin
        seg.ack <= 1'b0;
      end
    end else if (seg.req) begin
      cur_x     <= seg.x;
      cur_y     <= seg.y;
      remain    <= seg.len;
      vert      <= seg.vertical;
      pix_color <= seg.color;
      if (seg.len == '0) begin
        seg.ack <= 1'b1;  // empty run, nothing to write
      end else begin
        busy <= 1'b1;
      end
    end
  end

endmodule

// File: logic/frame_buffer.sv
//==========================================================================
// frame buffer, one pixel write port and one registered read port
// addressed by screen coordinates
//==========================================================================
module frame_buffer
  import gfx_pkg::*;
(
  input  logic     clk,
  input  logic     wr_en,
  input  fb_addr_t wr_addr,
  input  color_t   wr_data,
  input  coord_t   rd_x,
  input  coord_t   rd_y,
  output color_t   rd_color
);

  color_t mem [FB_W*FB_H];

  logic rd_on_screen;

  assign rd_on_screen = (rd_x < FB_W) && (rd_y < FB_H);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // off screen reads give black
  always_ff @(posedge clk) begin
    if (rd_on_screen) begin
      rd_color <= mem[fb_addr(rd_x, rd_y)];
    end else begin
      rd_color <= '0;
    end
  end

endmodule

// File: logic/line_raster_top.sv
//==========================================================================
// line rasterizer top, line engine feeding the span writer which
// fills the frame buffer, readback through a coordinate read port
//==========================================================================
module line_raster_top
  import gfx_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   cmd_req,
  output logic   cmd_ack,
  input  coord_t x0,
  input  coord_t y0,
  input  coord_t x1,
  input  coord_t y1,
  input  color_t color,
  input  coord_t rd_x,
  input  coord_t rd_y,
  output color_t rd_color
);

  seg_if seg_i ();

  logic     wr_en;
  fb_addr_t wr_addr;
  color_t   wr_data;

  line_draw line_draw_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_req (cmd_req),
    .cmd_ack (cmd_ack),
    .x0      (x0),
    .y0      (y0),
    .x1      (x1),
    .y1      (y1),
    .color   (color),
    .seg     (seg_i.master)
  );

  span_writer span_writer_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .seg     (seg_i.slave),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  frame_buffer frame_buffer_i (
    .clk      (clk),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_x     (rd_x),
    .rd_y     (rd_y),
    .rd_color (rd_color)
  );

endmodule

// File: tb/line_raster_asserts.sv
//==========================================================================
// handshake assertions for the line engine and its segment channel
//==========================================================================
module line_raster_asserts
  import gfx_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input logic        cmd_ack,
  input draw_state_t state,
  input logic        seg_req,
  input logic        seg_ack,
  input coord_t      seg_x,
  input coord_t      seg_y,
  input len_t        seg_len,
  input logic        seg_vertical,
  input color_t      seg_color
);

  int assert_errors = 0;

  fields_stable: assert property (@(posedge clk) disable iff (!rst_n)
    seg_req && $past(seg_req) |-> $stable({seg_x, seg_y, seg_len, seg_vertical, seg_color}))
    else begin
      assert_errors++;
      $error("seg fields changed while req was high");
    end

  // slave answers only a pending request
  ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(seg_ack) |-> seg_req)
    else begin
      assert_errors++;
      $error("seg ack rose without req");
    end

  // ack as seen on the edge where req went up
  no_seg_during_ack: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(seg_req) |-> !$past(seg_ack))
    else begin
      assert_errors++;
      $error("new segment started while ack was high");
    end

  cmd_ack_reset: assert property (@(posedge clk)
    !rst_n |-> !cmd_ack)
    else begin
      assert_errors++;
      $error("cmd_ack high during reset");
    end

  // span writer acks only while the engine waits on a segment
  ack_while_waiting: assert property (@(posedge clk) disable iff (!rst_n)
    seg_ack |-> state inside {st_emit, st_wait_ack})
    else begin
      assert_errors++;
      $error("seg ack high while the engine was not waiting");
    end

endmodule

bind line_draw line_raster_asserts line_raster_asserts_i (
  .clk          (clk),
  .rst_n        (rst_n),
  .cmd_ack      (cmd_ack),
  .state        (state),
  .seg_req      (seg.req),
  .seg_ack      (seg.ack),
  .seg_x        (seg.x),
  .seg_y        (seg.y),
  .seg_len      (seg.len),
  .seg_vertical (seg.vertical),
  .seg_color    (seg.color)
);

// File: tb/line_raster_tb.sv
//==========================================================================
// line rasterizer testbench, draws lines through the command handshake
// and compares the whole screen against a Bresenham reference model
//==========================================================================
module line_raster_tb
  import gfx_pkg::*;
();

  localparam int WAIT_CYCLES = 4000;

  logic   clk = 1'b0;
  logic   rst_n;
  logic   cmd_req;
  logic   cmd_ack;
  coord_t x0, y0, x1, y1;
  coord_t rd_x, rd_y;
  color_t color;
  color_t rd_color;

  int          errors;
  int          checks;
  logic [31:0] lfsr;
  color_t      shadow [FB_W*FB_H];  // expected screen contents
  coord_t      exp_x[$];
  coord_t      exp_y[$];

  line_raster_top line_raster_top_i (.*);

  always #5 clk = ~clk;

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? (s >> 1) ^ 32'ha300_0000 : s >> 1;
  endfunction

  task automatic rand_bits(input int n, output logic [15:0] v);
    v = '0;
    repeat (n) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[14:0], lfsr[0]};
    end
  endtask

  // reference Bresenham, walks the major axis left to right
  function automatic void model_line(input coord_t px0, py0, px1, py1);
    coord_t a0, b0, a1, b1, t, b;
    int     da, db, err;
    logic   steep;
    exp_x.delete();
    exp_y.delete();
    da    = (px1 > px0) ? px1 - px0 : px0 - px1;
    db    = (py1 > py0) ? py1 - py0 : py0 - py1;
    steep = db > da;
    if (steep) begin
      a0  = py0;
      b0  = px0;
      a1  = py1;
      b1  = px1;
      err = da;
      da  = db;
      db  = err;
    end else begin
      a0 = px0;
      b0 = py0;
      a1 = px1;
      b1 = py1;
    end
    if (a0 > a1) begin
      t  = a0;
      a0 = a1;
      a1 = t;
      t  = b0;
      b0 = b1;
      b1 = t;
    end
    err = da / 2;
    b   = b0;
    for (int i = 0; i <= da; i++) begin
      exp_x.push_back(steep ? b : a0 + i);
      exp_y.push_back(steep ? a0 + i : b);
      err -= db;
      if (err < 0) begin  // minor axis steps
        b = (b0 < b1) ? b + 1 : b - 1;
        err += da;
      end
    end
  endfunction

  task automatic draw_line_cmd(input coord_t lx0, ly0, lx1, ly1, input color_t c);
    int n;
    model_line(lx0, ly0, lx1, ly1);
    foreach (exp_x[i]) begin
      if (exp_x[i] < FB_W && exp_y[i] < FB_H) begin
        shadow[exp_y[i] * FB_W + exp_x[i]] = c;
      end
    end
    @(posedge clk);
    x0      <= lx0;
    y0      <= ly0;
    x1      <= lx1;
    y1      <= ly1;
    color   <= c;
    cmd_req <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (cmd_ack !== 1'b1 && n < WAIT_CYCLES);
    if (cmd_ack !== 1'b1) begin
      errors++;
      $display("timeout: cmd_ack never rose for line (%0d,%0d)-(%0d,%0d)", lx0, ly0, lx1, ly1);
    end
    @(posedge clk);
    cmd_req <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (cmd_ack !== 1'b0 && n < WAIT_CYCLES);
    if (cmd_ack !== 1'b0) begin
      errors++;
      $display("timeout: cmd_ack stayed high after cmd_req fell");
    end
  endtask

  task automatic read_pixel(input coord_t x, input coord_t y, output color_t c);
    @(posedge clk);
    rd_x <= x;
    rd_y <= y;
    @(posedge clk);  // registered read
    @(negedge clk);
    c = rd_color;
  endtask

  task automatic compare_screen(input string tag);
    color_t c;
    for (int y = 0; y < FB_H; y++) begin
      for (int x = 0; x < FB_W; x++) begin
        read_pixel(x, y, c);
        check(c, shadow[y * FB_W + x], $sformatf("%s pixel (%0d,%0d)", tag, x, y));
      end
    end
  endtask

  task automatic report_test(input string name, input int e0);
    $display("%-16s %s, %0d errors", name, (errors == e0) ? "passed" : "failed", errors - e0);
  endtask

  task automatic paint_background();
    int e0;
    e0 = errors;
    for (int y = 0; y < FB_H; y++) begin
      draw_line_cmd(0, y, FB_W - 1, y, 16'h0800 + y);
    end
    compare_screen("background");
    report_test("background", e0);
  endtask

  task automatic axis_lines();
    int e0;
    e0 = errors;
    draw_line_cmd(2, 3, 20, 3, 16'hf100);
    draw_line_cmd(7, 25, 7, 1, 16'h00f2);  // crosses the horizontal one
    compare_screen("axis");
    report_test("axis lines", e0);
  endtask

  // both directions, and the mirrored line in both directions
  task automatic endpoint_orders();
    int e0;
    e0 = errors;
    for (int k = 0; k < 2; k++) begin
      coord_t xa, ya, xb, yb;
      xa = k ? 5 : 3;
      ya = k ? 4 : 10;
      xb = k ? 17 : 27;
      yb = k ? 24 : 14;
      draw_line_cmd(xa, ya, xb, yb, 16'h3a00 + k);
      compare_screen("order 0");
      draw_line_cmd(xb, yb, xa, ya, 16'h3b00 + k);
      compare_screen("order 1");
      draw_line_cmd(xa, yb, xb, ya, 16'h3c00 + k);
      compare_screen("order 2");
      draw_line_cmd(xb, ya, xa, yb, 16'h3d00 + k);
      compare_screen("order 3");
    end
    report_test("endpoint orders", e0);
  endtask

  task automatic single_point();
    int e0;
    e0 = errors;
    draw_line_cmd(9, 9, 9, 9, 16'h5a5a);
    compare_screen("point");
    report_test("single point", e0);
  endtask

  task automatic clipped_lines();
    int     e0;
    color_t c;
    e0 = errors;
    draw_line_cmd(26, 20, 45, 20, 16'h7e01);  // x past 31 must not wrap to x - 32
    draw_line_cmd(3, 27, 3, 50, 16'h7e02);
    compare_screen("clip");
    read_pixel(40, 20, c);
    check(c, 16'h0000, "off screen read x");
    read_pixel(3, 40, c);
    check(c, 16'h0000, "off screen read y");
    report_test("clipped lines", e0);
  endtask

  task automatic random_lines();
    int          e0;
    logic [15:0] rx0, ry0, rx1, ry1, rc;
    e0 = errors;
    repeat (10) begin
      rand_bits(5, rx0);
      rand_bits(5, ry0);
      rand_bits(5, rx1);
      rand_bits(5, ry1);
      rand_bits(16, rc);
      draw_line_cmd(rx0, ry0, rx1, ry1, rc);
      compare_screen($sformatf("random (%0d,%0d)-(%0d,%0d)", rx0, ry0, rx1, ry1));
    end
    report_test("random lines", e0);
  endtask

  initial begin
    errors  = 0;
    checks  = 0;
    lfsr    = 32'hc08e;
    rst_n   = 1'b0;
    cmd_req = 1'b0;
    x0      = '0;
    y0      = '0;
    x1      = '0;
    y1      = '0;
    color   = '0;
    rd_x    = '0;
    rd_y    = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    paint_background();
    axis_lines();
    endpoint_orders();
    single_point();
    clipped_lines();
    random_lines();
    errors += line_raster_top_i.line_draw_i.line_raster_asserts_i.assert_errors;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
logic/gfx_pkg.sv
logic/seg_if.sv
logic/line_draw.sv
logic/span_writer.sv
logic/frame_buffer.sv
logic/line_raster_top.sv
tb/line_raster_asserts.sv
tb/line_raster_tb.sv

// File: Bender.yml
package:
  name: line_raster

sources:
  - logic/gfx_pkg.sv
  - logic/seg_if.sv
  - logic/line_draw.sv
  - logic/span_writer.sv
  - logic/frame_buffer.sv
  - logic/line_raster_top.sv
  - target: test
    files:
      - tb/line_raster_asserts.sv
      - tb/line_raster_tb.sv
